// ==== Makefile ====
# Verilator flow for the ring node testbench

VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       := tb_ring_node
FILELIST  := compile.f
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

# Static checks over the whole file list
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Build and run, the exit status of the binary is the test result
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
verilog/ring_pkg.sv
verilog/mem_port_if.sv
verilog/dp_ram.sv
verilog/nic_rx.sv
verilog/nic_tx.sv
verilog/ring_node.sv
tests/tb_ring_node.sv

// ==== tests/tb_ring_node.sv ====
module tb_ring_node;
	timeunit 1ns;
	timeprecision 1ps;
	import ring_pkg::*;

	localparam int       CLK_HALF      = 10;	// 20 ns clock period
	localparam int       RESET_CYCLES  = 8;
	localparam int       PIPE_DEPTH    = 8;	// Ring input to ring output in clocks
	localparam int       RESET_TIMEOUT = 32;
	localparam int       DRAIN_TIMEOUT = 4 * PIPE_DEPTH;
	localparam node_id_t NODE          = 5'd9;
	localparam core_id_t REMOTE        = {5'd3, 1'b1};	// Requester on another node
	localparam core_id_t FOREIGN       = {5'd4, 1'b0};	// Some core that is not ours

	// One table row where exp.valid tells whether a packet must come out
	typedef struct packed {
		ring_slot_t stim;
		ring_slot_t exp;
	} row_t;

	logic              clk_i = 1'b0;
	logic              arst_n_i;
	node_id_t          node_id_i;
	logic              ring_valid_i;
	ring_op_t          ring_op_i;
	core_id_t          ring_dst_i;
	core_id_t          ring_src_i;
	logic [SEL_W-1:0]  ring_sel_i;
	logic [ADDR_W-1:0] ring_addr_i;
	logic [DATA_W-1:0] ring_data_i;
	logic              ring_valid_o;
	ring_op_t          ring_op_o;
	core_id_t          ring_dst_o;
	core_id_t          ring_src_o;
	logic [SEL_W-1:0]  ring_sel_o;
	logic [ADDR_W-1:0] ring_addr_o;
	logic [DATA_W-1:0] ring_data_o;

	row_t              rows [$];	// Stimulus with expected output
	logic [DATA_W-1:0] model_mem [int];	// Expected RAM contents by word address
	logic [31:0]       lfsr;
	int                n_fail;

	ring_node dut0 (.*);

	always #CLK_HALF clk_i = ~clk_i;

	initial begin
		arst_n_i = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_i);
		arst_n_i <= 1'b1;
	end

	// ==================================================================
	// Helpers
	// ==================================================================

	// Galois LFSR step that returns the bit shifted out
	function automatic logic next_bit();
		logic bit_out;
		bit_out = lfsr[0];
		lfsr = lfsr >> 1;
		if (bit_out)
			lfsr = lfsr ^ 32'hD000_0001;	// Feedback taps
		return bit_out;
	endfunction

	function automatic logic [DATA_W-1:0] rand_word();
		logic [DATA_W-1:0] w;
		w = '0;
		for (int i = 0; i < DATA_W; i++)
			w = {w[DATA_W-2:0], next_bit()};	// One step per bit
		return w;
	endfunction

	function automatic core_id_t own_id(input logic core);
		return {NODE, core};
	endfunction

	function automatic ring_slot_t make_slot(input ring_op_t op, input core_id_t dst,
		input core_id_t src, input logic [SEL_W-1:0] sel,
		input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		ring_slot_t s;
		s.valid = 1'b1;
		s.op    = op;
		s.dst   = dst;
		s.src   = src;
		s.sel   = sel;
		s.addr  = addr;
		s.data  = data;
		return s;
	endfunction

	// Slot that no stage may touch
	task automatic add_pass(input ring_slot_t s);
		row_t r;
		r.stim = s;
		r.exp  = s;
		rows.push_back(r);
	endtask

	task automatic add_idle(input int n);
		for (int i = 0; i < n; i++)
			add_pass('0);
	endtask

	// A write is absorbed by its core and the slot leaves empty
	task automatic add_write(input logic core, input logic [SEL_W-1:0] sel,
		input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		row_t              r;
		logic [DATA_W-1:0] mask;
		logic [DATA_W-1:0] old;
		mask = '0;
		for (int i = 0; i < SEL_W; i++)
			mask[8*i +: 8] = {8{sel[i]}};	// Byte lane kept unless selected
		old = model_mem.exists(int'(addr)) ? model_mem[int'(addr)] : '0;
		model_mem[int'(addr)] = (old & ~mask) | (data & mask);
		r.stim = make_slot(OP_WRITE, own_id(core), REMOTE, sel, addr, data);
		r.exp  = '0;
		rows.push_back(r);
	endtask

	// A read turns around as a reply from the core to the requester
	task automatic add_read(input logic core, input core_id_t requester,
		input logic [ADDR_W-1:0] addr);
		row_t r;
		r.stim = make_slot(OP_READ, own_id(core), requester, '0, addr, rand_word());
		r.exp  = make_slot(OP_REPLY, requester, own_id(core), '0, addr,
			model_mem[int'(addr)]);
		rows.push_back(r);
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			n_fail++;
			$display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp);
			$display("FAIL: see errors above");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	task automatic check_row(input int idx);
		row_t r;
		r = rows[idx];
		check_value("ring_valid_o", 64'(ring_valid_o), 64'(r.exp.valid));
		if (r.exp.valid) begin	// Fields of an empty slot are don't care
			check_value("ring_op_o", 64'(ring_op_o), 64'(r.exp.op));
			check_value("ring_dst_o", 64'(ring_dst_o), 64'(r.exp.dst));
			check_value("ring_src_o", 64'(ring_src_o), 64'(r.exp.src));
			check_value("ring_sel_o", 64'(ring_sel_o), 64'(r.exp.sel));
			check_value("ring_addr_o", 64'(ring_addr_o), 64'(r.exp.addr));
			check_value("ring_data_o", 64'(ring_data_o), 64'(r.exp.data));
		end
	endtask

	task automatic drive_slot(input ring_slot_t s);
		ring_valid_i <= s.valid;
		ring_op_i    <= s.op;
		ring_dst_i   <= s.dst;
		ring_src_i   <= s.src;
		ring_sel_i   <= s.sel;
		ring_addr_i  <= s.addr;
		ring_data_i  <= s.data;
	endtask

	// ==================================================================
	// Stimulus table
	// ==================================================================

	task automatic build_table();
		// Traffic for another node and empty slots
		add_pass(make_slot(OP_WRITE, FOREIGN, REMOTE, 4'hF, 15'h0055, rand_word()));
		add_pass(make_slot(OP_READ, {5'd4, 1'b1}, REMOTE, 4'h0, 15'h0056, rand_word()));
		add_idle(1);
		add_pass(make_slot(OP_REPLY, FOREIGN, REMOTE, 4'h0, 15'h0057, rand_word()));
		add_write(1'b0, 4'hF, 15'h0010, rand_word());	// Write then read on core 0
		add_idle(1);
		add_read(1'b0, REMOTE, 15'h0010);
		add_write(1'b1, 4'hF, 15'h0123, rand_word());	// Written by core 1
		add_idle(5);	// Core 1 reaches the RAM four clocks later
		add_read(1'b0, REMOTE, 15'h0123);	// Read back through core 0
		add_write(1'b0, 4'hF, 15'h0200, rand_word());
		add_write(1'b0, 4'b0101, 15'h0200, rand_word());	// Lanes 1 and 3 stay
		add_read(1'b0, REMOTE, 15'h0200);
		add_idle(2);
		add_pass(make_slot(OP_REPLY, own_id(1'b1), REMOTE, 4'h0, 15'h0200, rand_word()));
		for (int i = 0; i < 4; i++) begin
			add_write(1'b0, 4'hF, ADDR_W'(15'h0300 + i), rand_word());
			add_write(1'b1, 4'hF, ADDR_W'(15'h0400 + i), rand_word());
		end
		add_idle(5);
		// Eight reads back to back fill the whole node
		for (int i = 0; i < 4; i++) begin
			add_read(1'b0, REMOTE, ADDR_W'(15'h0300 + i));
			add_read(1'b1, {5'd6, 1'b0}, ADDR_W'(15'h0400 + i));
		end
		add_idle(2);
	endtask

	// ==================================================================
	// Main sequence
	// ==================================================================

	initial begin
		int cycles;
		int n_checked;
		node_id_i    = NODE;
		ring_valid_i = 1'b0;
		ring_op_i    = OP_WRITE;
		ring_dst_i   = '0;
		ring_src_i   = '0;
		ring_sel_i   = '0;
		ring_addr_i  = '0;
		ring_data_i  = '0;
		lfsr         = 32'h3b71_87da;
		n_fail       = 0;
		build_table();

		cycles = 0;
		while (arst_n_i !== 1'b1 && cycles < RESET_TIMEOUT) begin
			@(posedge clk_i);
			cycles++;
		end
		if (arst_n_i !== 1'b1) begin
			$display("FAIL: see errors above");
			$fatal(1, "Reset was still asserted after %0d cycles", RESET_TIMEOUT);
		end
		@(negedge clk_i);
		check_value("ring_valid_o", 64'(ring_valid_o), 64'd0);	// Node comes up empty

		// Row i comes out PIPE_DEPTH clocks after it goes in
		n_checked = 0;
		for (int i = 0; i < rows.size(); i++) begin
			@(posedge clk_i);
			drive_slot(rows[i].stim);
			@(negedge clk_i);
			if (i >= PIPE_DEPTH) begin
				check_row(n_checked);
				n_checked++;
			end
		end

		cycles = 0;
		while (n_checked < rows.size() && cycles < DRAIN_TIMEOUT) begin
			@(posedge clk_i);
			drive_slot('0);
			@(negedge clk_i);
			check_row(n_checked);
			n_checked++;
			cycles++;
		end
		if (n_checked < rows.size()) begin
			$display("FAIL: see errors above");
			$fatal(1, "Only %0d of %0d rows came out of the node", n_checked, rows.size());
		end

		if (n_fail == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			$display("FAIL: see errors above");
			$fatal(1, "%0d checks failed", n_fail);
		end
	end

endmodule

// ==== verilog/dp_ram.sv ====
module dp_ram #(
	parameter int ADDR_W      = ring_pkg::ADDR_W,
	parameter int DATA_W      = ring_pkg::DATA_W,
	parameter int RAM_LATENCY = ring_pkg::RAM_LATENCY
) (
	input logic     clk_i,
	mem_port_if.ram a,	// Port owned by core 0
	mem_port_if.ram b	// Port owned by core 1
);
	localparam int SEL_W = DATA_W / 8;
	localparam int DEPTH = 2 ** ADDR_W;

	logic [DATA_W-1:0] mem [DEPTH];	// Contents are left as they power up

	// Read pipelines, element RAM_LATENCY-1 drives rdata
	logic [DATA_W-1:0] a_pipe [RAM_LATENCY];
	logic [DATA_W-1:0] b_pipe [RAM_LATENCY];

	// Replace only the byte lanes that are enabled
	function automatic logic [DATA_W-1:0] merge_bytes(
		input logic [DATA_W-1:0] old_word,
		input logic [DATA_W-1:0] new_word,
		input logic [SEL_W-1:0]  sel
	);
		logic [DATA_W-1:0] res;
		res = old_word;
		for (int i = 0; i < SEL_W; i++) begin
			if (sel[i])
				res[8*i +: 8] = new_word[8*i +: 8];
		end
		return res;
	endfunction

	// ==================================================================
	// Write side
	// ==================================================================

	// Both ports share one clock
	// Port B lands last if both hit the same word, which the ring never does
	always_ff @(posedge clk_i) begin
		if (a.en && (|a.we))
			mem[a.addr] <= merge_bytes(mem[a.addr], a.wdata, a.we);
		if (b.en && (|b.we))
			mem[b.addr] <= merge_bytes(mem[b.addr], b.wdata, b.we);
	end

	// ==================================================================
	// Read side
	// ==================================================================

	// The first stage loads only on a read, so rdata keeps the last word
	// through writes and idle cycles once the pipeline has drained
	always_ff @(posedge clk_i) begin
		if (a.en && !(|a.we))
			a_pipe[0] <= mem[a.addr];	// Sees a write made on an earlier edge
		if (b.en && !(|b.we))
			b_pipe[0] <= mem[b.addr];
		for (int k = 1; k < RAM_LATENCY; k++) begin
			a_pipe[k] <= a_pipe[k-1];	// Output register stages
			b_pipe[k] <= b_pipe[k-1];
		end
	end

	assign a.rdata = a_pipe[RAM_LATENCY-1];
	assign b.rdata = b_pipe[RAM_LATENCY-1];

	// Byte enables from a receive stage only ever come with a request
	a_we_needs_en: assert property (@(posedge clk_i) (|a.we) |-> a.en);
	b_we_needs_en: assert property (@(posedge clk_i) (|b.we) |-> b.en);

endmodule

// ==== verilog/mem_port_if.sv ====
// One port of the shared RAM
// The receive stage drives the request side and the transmit stage of the
// same core picks up rdata, so both sit on the nic modport
interface mem_port_if #(
	parameter int ADDR_W = ring_pkg::ADDR_W,
	parameter int DATA_W = ring_pkg::DATA_W
);
	localparam int SEL_W = DATA_W / 8;	// Byte lanes per word

	logic              en;	// Access this cycle, read or write
	logic [SEL_W-1:0]  we;	// Byte write enables, all zero for a read
	logic [ADDR_W-1:0] addr;	// Word address
	logic [DATA_W-1:0] wdata;	// Write data
	logic [DATA_W-1:0] rdata;	// Read data, pipelined by the RAM

	modport nic (
		output en,
		output we,
		output addr,
		output wdata,
		input  rdata
	);

	modport ram (
		input  en,
		input  we,
		input  addr,
		input  wdata,
		output rdata
	);

endinterface

// ==== verilog/nic_rx.sv ====
module nic_rx #(
	parameter bit CORE = 1'b0	// Core bit appended to the node number
) (
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	input  ring_pkg::node_id_t   node_id_i,
	input  ring_pkg::ring_slot_t slot_i,
	output ring_pkg::ring_slot_t slot_o,
	mem_port_if.nic              mem	// Request side of this core's RAM port
);
	import ring_pkg::*;

	core_id_t   own_id;	// Identifier this stage answers to
	logic       hit;	// Valid slot addressed to this core
	logic       is_wr;
	logic       is_rd;
	ring_slot_t slot_d;	// Slot as it leaves this stage
	ring_slot_t slot_q;	// Payload register
	logic       valid_q;	// Valid bit of the output slot

	assign own_id = {node_id_i, CORE};
	assign hit    = slot_i.valid && (slot_i.dst == own_id);
	assign is_wr  = hit && (slot_i.op == OP_WRITE);
	assign is_rd  = hit && (slot_i.op == OP_READ);

	// ==================================================================
	// Slot rewrite
	// ==================================================================

	// Replies and foreign traffic go through untouched
	always_comb begin
		slot_d = slot_i;
		if (is_wr) begin
			slot_d.valid = 1'b0;	// Write is absorbed and the slot frees up
		end else if (is_rd) begin
			// Turn the request around toward the sender
			// The transmit stage fills data once the RAM answers
			slot_d.op   = OP_PEND;
			slot_d.dst  = slot_i.src;
			slot_d.src  = own_id;
			slot_d.data = '0;
		end
	end

	// ==================================================================
	// Registers
	// ==================================================================

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q <= 1'b0;
			mem.en  <= 1'b0;
			mem.we  <= '0;
		end else begin
			valid_q <= slot_d.valid;
			mem.en  <= is_wr || is_rd;	// RAM takes it on the next edge
			mem.we  <= is_wr ? slot_i.sel : '0;
		end
	end

	// Address and data only matter while en is high
	always_ff @(posedge clk_i) begin
		slot_q    <= slot_d;
		mem.addr  <= slot_i.addr;
		mem.wdata <= slot_i.data;
	end

	always_comb begin
		slot_o       = slot_q;
		slot_o.valid = valid_q;
	end

	// The previous transmit stage must have resolved every pending reply
	no_pend_in: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		slot_i.valid |-> (slot_i.op != OP_PEND));

	// A RAM write frees the slot and a RAM read leaves a pending reply,
	// so the two never line up on the same request
	wr_not_rd: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		mem.en |-> ((|mem.we) != (slot_o.valid && slot_o.op == OP_PEND)));

endmodule

// ==== verilog/nic_tx.sv ====
module nic_tx #(
	parameter int RAM_LATENCY = ring_pkg::RAM_LATENCY
) (
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	input  ring_pkg::ring_slot_t slot_i,
	output ring_pkg::ring_slot_t slot_o,
	mem_port_if.nic              mem	// Read data and the request it answers
);
	import ring_pkg::*;

	// Delay line that keeps each slot in step with its RAM read
	ring_slot_t             sh_q [RAM_LATENCY];
	logic [RAM_LATENCY-1:0] sh_v_q;	// Valid bits of the delay line

	ring_slot_t last;	// Slot at the end of the delay line
	logic       last_v;
	ring_slot_t out_d;
	ring_slot_t out_q;
	logic       out_v_q;

	assign last   = sh_q[RAM_LATENCY-1];
	assign last_v = sh_v_q[RAM_LATENCY-1];

	// ==================================================================
	// Reply merge
	// ==================================================================

	// rdata belongs to the read issued together with this slot
	always_comb begin
		out_d = last;
		if (last_v && (last.op == OP_PEND)) begin
			out_d.op   = OP_REPLY;
			out_d.data = mem.rdata;
		end
	end

	// ==================================================================
	// Registers
	// ==================================================================

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sh_v_q  <= '0;
			out_v_q <= 1'b0;
		end else begin
			sh_v_q[0] <= slot_i.valid;
			for (int k = 1; k < RAM_LATENCY; k++)
				sh_v_q[k] <= sh_v_q[k-1];
			out_v_q <= last_v;
		end
	end

	// Payload moves every clock since the ring never stalls
	always_ff @(posedge clk_i) begin
		sh_q[0] <= slot_i;
		for (int k = 1; k < RAM_LATENCY; k++)
			sh_q[k] <= sh_q[k-1];
		out_q <= out_d;
	end

	always_comb begin
		slot_o       = out_q;
		slot_o.valid = out_v_q;
	end

	// A pending reply reaches the merge exactly when the RAM answers
	// the read that the receive stage issued for it
	pend_has_read: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(last_v && (last.op == OP_PEND)) |-> $past(mem.en && !(|mem.we), RAM_LATENCY));

endmodule

// ==== verilog/ring_node.sv ====
module ring_node #(
	parameter int ADDR_W      = ring_pkg::ADDR_W,	// RAM word address width
	parameter int DATA_W      = ring_pkg::DATA_W,	// RAM word width
	parameter int RAM_LATENCY = ring_pkg::RAM_LATENCY	// RAM read latency
) (
	input  logic                         clk_i,
	input  logic                         arst_n_i,
	input  ring_pkg::node_id_t           node_id_i,	// This node on the ring

	// Slot coming in from the previous node
	input  logic                         ring_valid_i,
	input  ring_pkg::ring_op_t           ring_op_i,
	input  ring_pkg::core_id_t           ring_dst_i,
	input  ring_pkg::core_id_t           ring_src_i,
	input  logic [ring_pkg::SEL_W-1:0]   ring_sel_i,
	input  logic [ring_pkg::ADDR_W-1:0]  ring_addr_i,
	input  logic [ring_pkg::DATA_W-1:0]  ring_data_i,

	// Slot going out to the next node
	output logic                         ring_valid_o,
	output ring_pkg::ring_op_t           ring_op_o,
	output ring_pkg::core_id_t           ring_dst_o,
	output ring_pkg::core_id_t           ring_src_o,
	output logic [ring_pkg::SEL_W-1:0]   ring_sel_o,
	output logic [ring_pkg::ADDR_W-1:0]  ring_addr_o,
	output logic [ring_pkg::DATA_W-1:0]  ring_data_o
);
	import ring_pkg::*;

	ring_slot_t ring_in;	// Slot entering core 0
	ring_slot_t rx0_slot;	// Core 0 after the receive stage
	ring_slot_t tx0_slot;	// Core 0 output and core 1 input
	ring_slot_t rx1_slot;	// Core 1 after the receive stage
	ring_slot_t ring_out;	// Slot leaving core 1

	// One RAM port per core
	mem_port_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) port_a ();
	mem_port_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) port_b ();

	assign ring_in = '{
		valid: ring_valid_i,
		op:    ring_op_i,
		dst:   ring_dst_i,
		src:   ring_src_i,
		sel:   ring_sel_i,
		addr:  ring_addr_i,
		data:  ring_data_i
	};

	// ==================================================================
	// Core 0 on port A
	// ==================================================================

	nic_rx #(.CORE(1'b0)) rx0 (
		.clk_i     (clk_i),
		.arst_n_i  (arst_n_i),
		.node_id_i (node_id_i),
		.slot_i    (ring_in),
		.slot_o    (rx0_slot),
		.mem       (port_a)
	);

	nic_tx #(.RAM_LATENCY(RAM_LATENCY)) tx0 (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.slot_i   (rx0_slot),
		.slot_o   (tx0_slot),
		.mem      (port_a)	// Picks up rdata for its pending replies
	);

	// ==================================================================
	// Core 1 on port B
	// ==================================================================

	nic_rx #(.CORE(1'b1)) rx1 (
		.clk_i     (clk_i),
		.arst_n_i  (arst_n_i),
		.node_id_i (node_id_i),
		.slot_i    (tx0_slot),
		.slot_o    (rx1_slot),
		.mem       (port_b)
	);

	nic_tx #(.RAM_LATENCY(RAM_LATENCY)) tx1 (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.slot_i   (rx1_slot),
		.slot_o   (ring_out),
		.mem      (port_b)
	);

	// Both cores see the same words
	dp_ram #(
		.ADDR_W      (ADDR_W),
		.DATA_W      (DATA_W),
		.RAM_LATENCY (RAM_LATENCY)
	) ram0 (
		.clk_i (clk_i),
		.a     (port_a),
		.b     (port_b)
	);

	assign ring_valid_o = ring_out.valid;
	assign ring_op_o    = ring_out.op;
	assign ring_dst_o   = ring_out.dst;
	assign ring_src_o   = ring_out.src;
	assign ring_sel_o   = ring_out.sel;
	assign ring_addr_o  = ring_out.addr;
	assign ring_data_o  = ring_out.data;

endmodule

// ==== verilog/ring_pkg.sv ====
package ring_pkg;

	// ==================================================================
	// Identifiers and widths
	// ==================================================================

	typedef logic [4:0] node_id_t;	// Node number on the ring
	typedef logic [5:0] core_id_t;	// Node number with the core bit as LSB

	localparam int ADDR_W = 15;	// Word address into the shared RAM
	localparam int DATA_W = 32;	// One RAM word
	localparam int SEL_W  = DATA_W / 8;	// One write enable per byte lane

	// Read data shows up this many clocks after the RAM takes the request
	localparam int RAM_LATENCY = 2;

	// ==================================================================
	// Slot format
	// ==================================================================

	// OP_PEND never leaves a node
	// The receive stage marks a read with it and the transmit stage
	// swaps it for OP_REPLY once the RAM word has been merged in
	typedef enum logic [1:0] {
		OP_WRITE = 2'd0,	// Store data at addr of the dst core
		OP_READ  = 2'd1,	// Fetch the word at addr of the dst core
		OP_REPLY = 2'd2,	// Returned word heading back to the requester
		OP_PEND  = 2'd3	// Reply still waiting for RAM data
	} ring_op_t;

	// One ring slot, 66 bits with valid as the MSB
	typedef struct packed {
		logic              valid;	// Slot carries a packet
		ring_op_t          op;
		core_id_t          dst;	// Target node and core
		core_id_t          src;	// Sender node and core
		logic [SEL_W-1:0]  sel;	// Byte enables for a write
		logic [ADDR_W-1:0] addr;	// Word address
		logic [DATA_W-1:0] data;	// Write data or returned read data
	} ring_slot_t;

endpackage
